/* sim.f */
src/cop_pkg.sv
src/cpr_wr_if.sv
src/cop_regfile.sv
src/cop_decode.sv
src/cop_malu.sv
src/cop_balu.sv
src/cop_wb_arbiter.sv
src/cop_top.sv
test/tb_cop.sv

/* run_sim.sh */
#!/bin/sh
# Build the coprocessor testbench with Verilator and run it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module tb_cop -f sim.f -o tb_cop_sim &&
./obj_dir/tb_cop_sim ||
{ echo "Simulation did not complete successfully"; exit 1; }

/* test/tb_cop_vectors.hex */
// Preload count, then (register, value) pairs; instruction count, then instruction words;
// read-back count, then (register, expected value) pairs
00000006
00000002 ffffffff 00000003 00000001 00000004 80000001
00000005 12345678 00000006 0000000c 00000007 0f0f0f0f
0000000d
00021401
0003ad12
00211609
0003e582
00329f11
0403a829
00280431
0002b91a
00000007
001a0639
0004698a
00192321
0206ca19
00000010
00000000 780f0f0f 00000001 00123456 00000002 0d0b0907 00000003 9234567b
00000004 00000030 00000005 00000010 00000006 00000010 00000007 00000000
00000008 92345678 00000009 00000001 0000000a 1d3b5977 0000000b 0f0f0f0f
0000000c 00000001 0000000d 00000003 0000000e 45678000 0000000f 00001123

/* test/tb_cop.sv */
// Testbench for the crypto coprocessor
// Replays the instruction stream from the vectors file against a register model

`timescale 1ns/1ps

module tb_cop;
    import cop_pkg::*;

    logic        g_clk;
    logic        g_resetn;
    logic        instr_valid;
    logic [31:0] instr;
    logic        instr_stall;
    logic [3:0]  dbg_addr;
    logic [31:0] dbg_rdata;
    logic        wb_valid;
    logic [3:0]  wb_addr;
    logic [31:0] wb_data;

    logic [31:0] vec [0:79];
    logic [31:0] model [16];        // Expected CPR contents
    logic [3:0]  exp_addr [$];      // Expected writes in grant order
    logic [31:0] exp_data [$];
    integer      seed = 32'h5cac;
    int          n_instr = 0;

    cop_top cop_top_inst (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_stall (instr_stall),
        .dbg_addr    (dbg_addr),
        .dbg_rdata   (dbg_rdata),
        .wb_valid    (wb_valid),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data)
    );

    initial g_clk = 1'b0;
    always #20 g_clk = ~g_clk;

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Some tests failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic expect_write(input logic [3:0] addr, input logic [31:0] data);
        model[addr] = data;
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // Reference behavior of one accepted instruction
    task automatic apply_model(input logic [31:0] w);
        logic [2:0]  cls;
        logic [3:0]  sc;
        logic [3:0]  rd;
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        logic [3:0]  rs3;
        logic [5:0]  imm;
        logic [63:0] pair;
        logic [63:0] res;
        cls  = w[2:0];
        sc   = w[6:3];
        rd   = w[10:7];
        rs1  = w[14:11];
        rs2  = w[18:15];
        rs3  = w[22:19];
        imm  = w[28:23];
        pair = {model[rs1], model[rs2]};    // Shift source with rs1 as the high word
        if (cls == class_malu) begin
            case (sc)
                sclass_add2: res = {32'b0, model[rs1]} + {32'b0, model[rs2]};
                sclass_add3: res = {32'b0, model[rs1]} + {32'b0, model[rs2]}
                                   + {32'b0, model[rs3]};
                sclass_sll:  res = pair << model[rs3][5:0];
                sclass_slli: res = pair << imm;
                sclass_srl:  res = pair >> model[rs3][5:0];
                sclass_srli: res = pair >> imm;
                sclass_acc1: res = {model[rd | 4'd1], model[rd]} + {32'b0, model[rs3]};
                sclass_acc2: res = {model[rd | 4'd1], model[rd]} + {32'b0, model[rs2]}
                                   + {32'b0, model[rs3]};
                default:     res = 64'b0;
            endcase
            expect_write(rd, res[31:0]);
            expect_write(rd | 4'd1, res[63:32]);
        end else if (cls == class_balu) begin
            case (sc)
                sclass_and:  expect_write(rd, model[rs1] & model[rs2]);
                sclass_or:   expect_write(rd, model[rs1] | model[rs2]);
                sclass_xor:  expect_write(rd, model[rs1] ^ model[rs2]);
                sclass_andn: expect_write(rd, model[rs1] & ~model[rs2]);
                default:     expect_write(rd, 32'b0);
            endcase
        end
        // Reserved classes retire without a write
    endtask

    // Hold the instruction until the DUT takes it
    task automatic issue(input logic [31:0] w, input logic idle);
        @(negedge g_clk);
        instr_valid = 1'b1;
        instr       = w;
        #1;
        // Nothing in flight, or a reserved class, is taken at once
        if (idle || (w[2:0] != class_malu && w[2:0] != class_balu)) begin
            check({31'b0, instr_stall}, 32'd0, "instruction stalled with no unit busy");
        end
        while (instr_stall) begin
            @(negedge g_clk);
            #1;
        end
        @(posedge g_clk);
        apply_model(w);
    endtask

    // Every granted write must be the next one the model expects
    always @(negedge g_clk) begin
        if (g_resetn && wb_valid) begin
            check({31'b0, exp_addr.size() != 0}, 32'd1, "write-back with no pending write");
            check({28'b0, wb_addr}, {28'b0, exp_addr.pop_front()}, "write-back address");
            check(wb_data, exp_data.pop_front(), "write-back data");
        end
    end

    initial begin
        wait (n_instr != 0);
        repeat (n_instr * 4 + 100) @(posedge g_clk);
        $display("Timeout: the DUT did not finish the instruction stream in time");
        $display("Some tests failed");
        $fatal(1, "watchdog");
    end

    initial begin
        int base;
        int n_pre;
        int n_chk;
        int gap;
        logic [3:0] idx;
        g_resetn    = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        dbg_addr    = '0;
        for (int r = 0; r < 16; r++) begin
            model[r] = '0;
        end
        $readmemh("test/tb_cop_vectors.hex", vec);
        n_pre   = int'(vec[0]);
        base    = 1 + 2 * n_pre;
        n_instr = int'(vec[base]);
        n_chk   = int'(vec[base + 1 + n_instr]);
        if (n_instr == 0 || n_chk == 0) begin
            $display("The vectors file is missing or holds no instructions to check");
            $display("Some tests failed");
            $fatal(1, "no vectors");
        end

        repeat (8) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;

        // Seed the operands straight into the CPR
        @(negedge g_clk);
        check({31'b0, wb_valid}, 32'd0, "write-back valid after reset");
        for (int k = 0; k < n_pre; k++) begin
            idx = vec[1 + 2 * k][3:0];
            cop_top_inst.cop_regfile_inst.regs[idx] = vec[2 + 2 * k];
            model[idx] = vec[2 + 2 * k];
        end

        for (int k = 0; k < n_instr; k++) begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) begin
                @(negedge g_clk);
                instr_valid = 1'b0;
            end
            issue(vec[base + 1 + k], k == 0);
        end
        @(negedge g_clk);
        instr_valid = 1'b0;

        while (exp_addr.size() != 0) begin
            @(negedge g_clk);
        end
        repeat (2) @(negedge g_clk);

        base = base + 2 + n_instr;
        for (int k = 0; k < n_chk; k++) begin
            idx = vec[base + 2 * k][3:0];
            @(negedge g_clk);
            dbg_addr = idx;
            #1;
            check(model[idx], vec[base + 2 * k + 1], "model against vector file");
            check(dbg_rdata, vec[base + 2 * k + 1], "debug read of register");
        end

        $display("All tests passed");
        $finish;
    end

endmodule

/* src/cop_top.sv */
// Crypto coprocessor top level
// Decode, multi-precision and bitwise ALUs, write-back arbiter and CPR

`timescale 1ns/1ps

module cop_top (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  logic              instr_valid,
    input  cop_pkg::word_t    instr,
    output logic              instr_stall,
    input  cop_pkg::reg_idx_t dbg_addr,
    output cop_pkg::word_t    dbg_rdata,
    output logic              wb_valid,
    output cop_pkg::reg_idx_t wb_addr,
    output cop_pkg::word_t    wb_data
);
    import cop_pkg::*;

    reg_idx_t   ra1;
    reg_idx_t   ra2;
    reg_idx_t   ra3;
    word_t      rd1;
    word_t      rd2;
    word_t      rd3;
    logic       malu_ivalid;
    logic       malu_idone;
    logic       malu_rdm_in_rs;
    logic       balu_ivalid;
    logic       balu_idone;
    logic [3:0] subclass;
    reg_idx_t   rd;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      rs3_val;
    shamt_t     imm;
    ben_t       wben;

    cpr_wr_if malu_wr ();
    cpr_wr_if balu_wr ();

    cop_decode cop_decode_inst (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .instr_stall    (instr_stall),
        .ra1            (ra1),
        .ra2            (ra2),
        .ra3            (ra3),
        .rd1            (rd1),
        .rd2            (rd2),
        .rd3            (rd3),
        .malu_ivalid    (malu_ivalid),
        .malu_idone     (malu_idone),
        .malu_rdm_in_rs (malu_rdm_in_rs),
        .balu_ivalid    (balu_ivalid),
        .balu_idone     (balu_idone),
        .subclass       (subclass),
        .rd             (rd),
        .rs1_val        (rs1_val),
        .rs2_val        (rs2_val),
        .rs3_val        (rs3_val),
        .imm            (imm)
    );

    cop_malu cop_malu_inst (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .malu_ivalid    (malu_ivalid),
        .malu_idone     (malu_idone),
        .malu_rdm_in_rs (malu_rdm_in_rs),
        .subclass       (subclass),
        .rd             (rd),
        .rs1_val        (rs1_val),
        .rs2_val        (rs2_val),
        .rs3_val        (rs3_val),
        .imm            (imm),
        .wr             (malu_wr.unit)
    );

    cop_balu cop_balu_inst (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .balu_ivalid (balu_ivalid),
        .balu_idone  (balu_idone),
        .subclass    (subclass),
        .rd          (rd),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .wr          (balu_wr.unit)
    );

    // Granted write doubles as the write-back observation port
    cop_wb_arbiter cop_wb_arbiter_inst (
        .malu_wr (malu_wr.arb),
        .balu_wr (balu_wr.arb),
        .we      (wb_valid),
        .waddr   (wb_addr),
        .wben    (wben),
        .wdata   (wb_data)
    );

    cop_regfile cop_regfile_inst (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .ra1       (ra1),
        .ra2       (ra2),
        .ra3       (ra3),
        .rd1       (rd1),
        .rd2       (rd2),
        .rd3       (rd3),
        .dbg_addr  (dbg_addr),
        .dbg_rdata (dbg_rdata),
        .we        (wb_valid),
        .waddr     (wb_addr),
        .wben      (wben),
        .wdata     (wb_data)
    );

endmodule

/* src/cop_wb_arbiter.sv */
// Write-back arbiter for the single CPR write port
// Fixed priority, the multi-precision ALU always wins over the bitwise ALU

`timescale 1ns/1ps

module cop_wb_arbiter (
    cpr_wr_if.arb             malu_wr,
    cpr_wr_if.arb             balu_wr,
    output logic              we,
    output cop_pkg::reg_idx_t waddr,
    output cop_pkg::ben_t     wben,
    output cop_pkg::word_t    wdata
);

    logic malu_gnt;
    logic balu_gnt;

    assign malu_gnt = malu_wr.wr_req;
    assign balu_gnt = balu_wr.wr_req && !malu_wr.wr_req;   // Waits out a MALU write

    assign malu_wr.wr_gnt = malu_gnt;
    assign balu_wr.wr_gnt = balu_gnt;

    assign we = malu_gnt || balu_gnt;

    // Winner's write fields to the register file
    always_comb begin
        if (malu_gnt) begin
            waddr = malu_wr.wr_addr;
            wben  = malu_wr.wr_ben;
            wdata = malu_wr.wr_data;
        end else if (balu_gnt) begin
            waddr = balu_wr.wr_addr;
            wben  = balu_wr.wr_ben;
            wdata = balu_wr.wr_data;
        end else begin
            waddr = '0;
            wben  = '0;
            wdata = '0;
        end
    end

endmodule

/* src/cop_balu.sv */
// Bitwise ALU
// Single-cycle logic ops, result held in a one-entry register until granted

`timescale 1ns/1ps

module cop_balu (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  logic              balu_ivalid,
    output logic              balu_idone,
    input  logic [3:0]        subclass,
    input  cop_pkg::reg_idx_t rd,
    input  cop_pkg::word_t    rs1_val,
    input  cop_pkg::word_t    rs2_val,
    cpr_wr_if.unit            wr
);
    import cop_pkg::*;

    word_t    res_d;
    word_t    res_q;
    reg_idx_t rd_q;
    logic     pend;     // Result waiting for the write port

    always_comb begin
        case (balu_sclass_e'(subclass))
            sclass_and:  res_d = rs1_val & rs2_val;
            sclass_or:   res_d = rs1_val | rs2_val;
            sclass_xor:  res_d = rs1_val ^ rs2_val;
            sclass_andn: res_d = rs1_val & ~rs2_val;
            default:     res_d = '0;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pend <= 1'b0;
        end else if (balu_ivalid) begin
            pend <= 1'b1;
        end else if (wr.wr_gnt) begin
            pend <= 1'b0;
        end
    end

    always_ff @(posedge g_clk) begin
        if (balu_ivalid) begin
            res_q <= res_d;
            rd_q  <= rd;
        end
    end

    assign wr.wr_req  = pend;
    assign wr.wr_addr = rd_q;
    assign wr.wr_ben  = ben_full;
    assign wr.wr_data = res_q;
    assign balu_idone = pend && wr.wr_gnt;

endmodule

/* src/cop_malu.sv */
// Multi-precision ALU
// Two and three word add, 64-bit shifts and accumulate into the rd pair.
// Each result goes back as the low word to rd, then the high word to rd|1.

`timescale 1ns/1ps

module cop_malu (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  logic              malu_ivalid,      // Held by decode until done
    output logic              malu_idone,
    output logic              malu_rdm_in_rs,   // Wants the rd pair in rs1/rs2
    input  logic [3:0]        subclass,
    input  cop_pkg::reg_idx_t rd,
    input  cop_pkg::word_t    rs1_val,
    input  cop_pkg::word_t    rs2_val,
    input  cop_pkg::word_t    rs3_val,
    input  cop_pkg::shamt_t   imm,
    cpr_wr_if.unit            wr
);
    import cop_pkg::*;

    malu_step_e   step;
    malu_sclass_e sclass_q;     // Issue fields kept past step0
    reg_idx_t     rd_q;
    malu_sclass_e sclass;
    reg_idx_t     rd_cur;
    dword_t       inter;

    logic is_add3;
    logic is_acc1;
    logic is_acc2;
    logic is_long;
    logic shift_reg;
    logic shift_imm;
    logic shift_right;
    logic is_shift;
    logic wr_lo;
    logic wr_hi;
    logic advance;

    dword_t add_lhs;
    dword_t add_rhs;
    dword_t add_res;
    dword_t shift_lhs;
    dword_t shift_res;
    shamt_t shamt;
    dword_t result;

    // Decode drives the issue fields on step0 only
    assign sclass = (step == step0) ? malu_sclass_e'(subclass) : sclass_q;
    assign rd_cur = (step == step0) ? rd : rd_q;

    assign is_add3     = sclass == sclass_add3;
    assign is_acc1     = sclass == sclass_acc1;
    assign is_acc2     = sclass == sclass_acc2;
    assign is_long     = is_add3 || is_acc2;       // One compute step before the writes
    assign shift_reg   = sclass == sclass_sll || sclass == sclass_srl;
    assign shift_imm   = sclass == sclass_slli || sclass == sclass_srli;
    assign shift_right = sclass == sclass_srl || sclass == sclass_srli;
    assign is_shift    = shift_reg || shift_imm;

    assign malu_rdm_in_rs = malu_ivalid && step == step0 && (is_acc1 || is_acc2);

    // Single 64-bit adder, operands picked by step
    always_comb begin
        if (step == step0) begin
            case (sclass)
                sclass_add2, sclass_add3: begin
                    add_lhs = {32'b0, rs1_val};
                    add_rhs = {32'b0, rs2_val};
                end
                default: begin
                    add_lhs = {rs2_val, rs1_val};   // Current rd pair
                    add_rhs = {32'b0, rs3_val};
                end
            endcase
        end else begin
            add_lhs = inter;
            add_rhs = {32'b0, is_acc2 ? rs2_val : rs3_val};
        end
    end

    assign add_res = add_lhs + add_rhs;    // Carry out of bit 63 is dropped

    // Barrel shifter over rs1:rs2
    assign shamt     = shift_reg ? rs3_val[5:0] : imm;
    assign shift_lhs = {rs1_val, rs2_val};
    assign shift_res = shift_right ? shift_lhs >> shamt : shift_lhs << shamt;

    assign result = is_shift ? shift_res : add_res;

    // Low word on the first write step, high word from the register after
    assign wr_lo = is_long ? step == step1 : step == step0;
    assign wr_hi = is_long ? step == step2 : step == step1;

    assign wr.wr_req  = malu_ivalid && (wr_lo || wr_hi);
    assign wr.wr_addr = wr_hi ? (rd_cur | 4'd1) : rd_cur;
    assign wr.wr_ben  = ben_full;
    assign wr.wr_data = wr_hi ? inter[63:32] : result[31:0];

    assign malu_idone = wr.wr_req && wr.wr_gnt && wr_hi;

    assign advance = malu_ivalid && (!wr.wr_req || wr.wr_gnt);

    always_ff @(posedge g_clk) begin
        if (!g_resetn || malu_idone) begin
            step <= step0;
        end else if (advance) begin
            step <= (step == step0) ? step1 : step2;
        end
    end

    always_ff @(posedge g_clk) begin
        if (malu_ivalid && step == step0) begin
            sclass_q <= sclass;
            rd_q     <= rd;
        end
        if (advance && (step == step0 || step == step1 && is_long)) begin
            inter <= result;
        end
    end

endmodule

/* src/cop_decode.sv */
// Coprocessor decode and issue
// Latches multi-precision ops until done, passes bitwise ops straight on,
// and stalls the instruction input on busy units or pair hazards

`timescale 1ns/1ps

module cop_decode (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  logic              instr_valid,
    input  cop_pkg::word_t    instr,
    output logic              instr_stall,
    output cop_pkg::reg_idx_t ra1,
    output cop_pkg::reg_idx_t ra2,
    output cop_pkg::reg_idx_t ra3,
    input  cop_pkg::word_t    rd1,
    input  cop_pkg::word_t    rd2,
    input  cop_pkg::word_t    rd3,
    output logic              malu_ivalid,
    input  logic              malu_idone,
    input  logic              malu_rdm_in_rs,
    output logic              balu_ivalid,
    input  logic              balu_idone,
    output logic [3:0]        subclass,
    output cop_pkg::reg_idx_t rd,
    output cop_pkg::word_t    rs1_val,
    output cop_pkg::word_t    rs2_val,
    output cop_pkg::word_t    rs3_val,
    output cop_pkg::shamt_t   imm
);
    import cop_pkg::*;

    cop_class_e f_class;
    logic [3:0] f_sclass;
    reg_idx_t   f_rd;
    reg_idx_t   f_rs1;
    reg_idx_t   f_rs2;
    reg_idx_t   f_rs3;
    shamt_t     f_imm;

    logic       m_busy;     // Multi-precision op in flight
    logic [1:0] m_own;      // Cycles left where the MALU reads the issue fields
    logic [3:0] m_sclass;
    reg_idx_t   m_rd;
    reg_idx_t   m_rs1;
    reg_idx_t   m_rs2;
    reg_idx_t   m_rs3;
    shamt_t     m_imm;
    logic       b_busy;     // Bitwise result waiting for its write

    logic is_malu;
    logic is_balu;
    logic hazard;
    logic malu_go;

    assign f_class  = cop_class_e'(instr[instr_class_lsb +: 3]);
    assign f_sclass = instr[instr_sclass_lsb +: 4];
    assign f_rd     = instr[instr_rd_lsb +: 4];
    assign f_rs1    = instr[instr_rs1_lsb +: 4];
    assign f_rs2    = instr[instr_rs2_lsb +: 4];
    assign f_rs3    = instr[instr_rs3_lsb +: 4];
    assign f_imm    = instr[instr_imm_lsb +: 6];

    assign is_malu = instr_valid && f_class == class_malu;
    assign is_balu = instr_valid && f_class == class_balu;

    // Touches the pair the MALU is still writing
    assign hazard = m_busy && (f_rs1[3:1] == m_rd[3:1] ||
                               f_rs2[3:1] == m_rd[3:1] ||
                               f_rd[3:1]  == m_rd[3:1]);

    // New MALU op also waits behind a held bitwise result
    assign instr_stall = is_malu && (m_busy || b_busy) ||
                         is_balu && (b_busy || m_own != 2'd0 || hazard);

    assign malu_go     = is_malu && !instr_stall;
    assign balu_ivalid = is_balu && !instr_stall;
    assign malu_ivalid = m_busy;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            m_busy <= 1'b0;
            m_own  <= 2'd0;
            b_busy <= 1'b0;
        end else begin
            if (malu_go) begin
                m_busy <= 1'b1;
                // add3 and acc2 read operands on two steps
                m_own  <= (f_sclass == sclass_add3 || f_sclass == sclass_acc2) ? 2'd2 : 2'd1;
            end else begin
                if (malu_idone) begin
                    m_busy <= 1'b0;
                end
                if (m_own != 2'd0) begin
                    m_own <= m_own - 2'd1;
                end
            end
            if (balu_ivalid) begin
                b_busy <= 1'b1;
            end else if (balu_idone) begin
                b_busy <= 1'b0;
            end
        end
    end

    // Instruction register for the MALU
    always_ff @(posedge g_clk) begin
        if (malu_go) begin
            m_sclass <= f_sclass;
            m_rd     <= f_rd;
            m_rs1    <= f_rs1;
            m_rs2    <= f_rs2;
            m_rs3    <= f_rs3;
            m_imm    <= f_imm;
        end
    end

    always_comb begin
        if (m_own != 2'd0) begin
            subclass = m_sclass;
            rd       = m_rd;
            imm      = m_imm;
            ra1      = malu_rdm_in_rs ? m_rd : m_rs1;            // Accumulate reads rd pair
            ra2      = malu_rdm_in_rs ? (m_rd | 4'd1) : m_rs2;
            ra3      = m_rs3;
        end else begin
            subclass = f_sclass;
            rd       = f_rd;
            imm      = f_imm;
            ra1      = f_rs1;
            ra2      = f_rs2;
            ra3      = f_rs3;
        end
    end

    assign rs1_val = rd1;
    assign rs2_val = rd2;
    assign rs3_val = rd3;

endmodule

/* src/cop_regfile.sv */
// Coprocessor register file
// 16 x 32 bits, three operand reads, one debug read, one byte-enabled write

`timescale 1ns/1ps

module cop_regfile (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  cop_pkg::reg_idx_t ra1,
    input  cop_pkg::reg_idx_t ra2,
    input  cop_pkg::reg_idx_t ra3,
    output cop_pkg::word_t    rd1,
    output cop_pkg::word_t    rd2,
    output cop_pkg::word_t    rd3,
    input  cop_pkg::reg_idx_t dbg_addr,
    output cop_pkg::word_t    dbg_rdata,
    input  logic              we,
    input  cop_pkg::reg_idx_t waddr,
    input  cop_pkg::ben_t     wben,
    input  cop_pkg::word_t    wdata
);
    import cop_pkg::*;

    word_t regs [cpr_entries];

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            for (int i = 0; i < cpr_entries; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (wben[b]) begin
                    regs[waddr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // Reads see the old value during a write cycle
    assign rd1       = regs[ra1];
    assign rd2       = regs[ra2];
    assign rd3       = regs[ra3];
    assign dbg_rdata = regs[dbg_addr];

endmodule

/* src/cpr_wr_if.sv */
// CPR write request of one execution unit and the grant returned to it

`timescale 1ns/1ps

interface cpr_wr_if;
    import cop_pkg::*;

    logic     wr_req;
    reg_idx_t wr_addr;
    ben_t     wr_ben;
    word_t    wr_data;
    logic     wr_gnt;   // Write lands when req and gnt are both high

    modport unit (
        output wr_req,
        output wr_addr,
        output wr_ben,
        output wr_data,
        input  wr_gnt
    );

    modport arb (
        input  wr_req,
        input  wr_addr,
        input  wr_ben,
        input  wr_data,
        output wr_gnt
    );

endinterface

/* src/cop_pkg.sv */
// Crypto coprocessor shared definitions
// Word widths, instruction field layout, unit and subclass encodings

package cop_pkg;

    typedef logic [31:0] word_t;    // CPR register value
    typedef logic [63:0] dword_t;   // Multi-precision intermediate
    typedef logic [3:0]  reg_idx_t;
    typedef logic [3:0]  ben_t;
    typedef logic [5:0]  shamt_t;

    localparam int   cpr_entries = 16;
    localparam ben_t ben_full    = 4'hf;

    // Instruction word field positions
    localparam int instr_class_lsb  = 0;
    localparam int instr_sclass_lsb = 3;
    localparam int instr_rd_lsb     = 7;
    localparam int instr_rs1_lsb    = 11;
    localparam int instr_rs2_lsb    = 15;
    localparam int instr_rs3_lsb    = 19;
    localparam int instr_imm_lsb    = 23;

    // Unit select, remaining codes are reserved no-ops
    typedef enum logic [2:0] {
        class_malu = 3'd1,
        class_balu = 3'd2
    } cop_class_e;

    typedef enum logic [3:0] {
        sclass_add2 = 4'd0,
        sclass_add3 = 4'd1,
        sclass_sll  = 4'd2,
        sclass_slli = 4'd3,
        sclass_srl  = 4'd4,
        sclass_srli = 4'd5,
        sclass_acc1 = 4'd6,
        sclass_acc2 = 4'd7
    } malu_sclass_e;

    typedef enum logic [3:0] {
        sclass_and  = 4'd0,
        sclass_or   = 4'd1,
        sclass_xor  = 4'd2,
        sclass_andn = 4'd3
    } balu_sclass_e;

    typedef enum logic [1:0] {
        step0 = 2'd0,
        step1 = 2'd1,
        step2 = 2'd2
    } malu_step_e;

endpackage
